// File: hw/cacheBusPkg.sv
`default_nettype none

// ********************
// CPU side payloads
// ********************

package cacheBusPkg;

	typedef enum logic {
		CpuRead,
		CpuWrite
	} cpuOpT;

	typedef struct packed {
		cpuOpT op;
		cacheGeometryPkg::addrT addr;
		cacheGeometryPkg::byteT writeByte;
	} cpuReqT;

	// ********************
	// Memory side payloads
	// ********************

	typedef enum logic {
		MemLineRead,
		MemLineWrite
	} memOpT;

	// Line address is tag and index, no offset
	typedef struct packed {
		memOpT op;
		struct packed {
			cacheGeometryPkg::tagT tag;
			cacheGeometryPkg::indexT index;
		} lineAddr;
		cacheGeometryPkg::lineT line;
	} memReqT;

	typedef struct packed {
		cacheGeometryPkg::lineT line;
	} memRespT;

endpackage

`default_nettype wire

// File: hw/cacheController.sv
`timescale 1ns/1ps
`default_nettype none

module cacheController #(
	parameter int NumWays = 4
) (
	input wire clk,
	input wire reset,
	input wire cpuReq,
	input wire cacheBusPkg::cpuReqT cpuReqData,
	output logic cpuAck,
	output cacheGeometryPkg::byteT cpuReadByte,
	output logic memReq,
	output cacheBusPkg::memReqT memReqData,
	input wire memAck,
	input wire cacheBusPkg::memRespT memRespData,
	input wire hit,
	input wire [$clog2(NumWays)-1:0] hitWay,
	input wire cacheGeometryPkg::byteT hitByte,
	input wire [NumWays-1:0] wayDirty,
	input wire cacheGeometryPkg::tagT [NumWays-1:0] wayTags,
	input wire cacheGeometryPkg::lineT [NumWays-1:0] wayLines,
	output cacheGeometryPkg::addrT lookupAddr,
	output logic [NumWays-1:0] tagWrite,
	output logic [NumWays-1:0] dataWrite,
	output logic refill,
	output cacheGeometryPkg::lineT refillLine,
	output cacheGeometryPkg::byteT writeByte,
	output logic [NumWays-1:0] dirtyWrite,
	output logic dirtyIn
);

	localparam int WayBits = $clog2(NumWays);

	typedef enum logic [2:0] {
		Idle,
		Lookup,
		Writeback,
		Refill,
		Update,
		Respond
	} stateT;

	stateT state;
	cacheBusPkg::cpuReqT req;
	logic [WayBits-1:0] victimWay;
	logic [WayBits-1:0] victim;
	logic [WayBits-1:0] rrPtr [cacheGeometryPkg::Sets];
	logic isWrite;

	assign lookupAddr = req.addr;
	assign writeByte = req.writeByte;
	assign isWrite = (req.op == cacheBusPkg::CpuWrite);
	assign victim = rrPtr[req.addr.index];

	// ********************
	// Way write strobes
	// ********************

	always_comb
	begin
		tagWrite = '0;
		dataWrite = '0;
		dirtyWrite = '0;
		refill = 1'b0;
		case (state)
			Lookup:
			begin
				// Write hit merges the byte and marks the line dirty
				if (hit && isWrite)
				begin
					dataWrite[hitWay] = 1'b1;
					dirtyWrite[hitWay] = 1'b1;
				end
			end
			Update:
			begin
				tagWrite[victimWay] = 1'b1;
				dataWrite[victimWay] = 1'b1;
				dirtyWrite[victimWay] = 1'b1;
				refill = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	// Dirty set on a write hit, cleared on refill
	assign dirtyIn = (state == Lookup);

	// ********************
	// Sequencing
	// ********************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= Idle;
			cpuAck <= 1'b0;
			memReq <= 1'b0;
			for (int s = 0; s < cacheGeometryPkg::Sets; s++)
				rrPtr[s] <= '0;
		end
		else
		begin
			case (state)
				Idle:
				begin
					if (cpuReq)
					begin
						req <= cpuReqData;
						state <= Lookup;
					end
				end
				Lookup:
				begin
					if (hit)
					begin
						cpuReadByte <= hitByte;
						state <= Respond;
					end
					else
					begin
						victimWay <= victim;
						memReq <= 1'b1;
						memReqData.lineAddr.index <= req.addr.index;
						if (wayDirty[victim])
						begin
							memReqData.op <= cacheBusPkg::MemLineWrite;
							memReqData.lineAddr.tag <= wayTags[victim];
							memReqData.line <= wayLines[victim];
							state <= Writeback;
						end
						else
						begin
							memReqData.op <= cacheBusPkg::MemLineRead;
							memReqData.lineAddr.tag <= req.addr.tag;
							memReqData.line <= '0;
							state <= Refill;
						end
					end
				end
				Writeback:
				begin
					if (memReq && memAck)
						memReq <= 1'b0;
					else if (!memReq && !memAck)
					begin
						// Victim is out, now fetch the requested line
						memReq <= 1'b1;
						memReqData.op <= cacheBusPkg::MemLineRead;
						memReqData.lineAddr.tag <= req.addr.tag;
						memReqData.line <= '0;
						state <= Refill;
					end
				end
				Refill:
				begin
					if (memReq && memAck)
					begin
						refillLine <= memRespData.line;
						memReq <= 1'b0;
					end
					else if (!memReq && !memAck)
						state <= Update;
				end
				Update:
				begin
					rrPtr[req.addr.index] <= victimWay + 1'b1;
					// Second lookup hits and handles the byte
					state <= Lookup;
				end
				Respond:
				begin
					if (!cpuAck)
						cpuAck <= 1'b1;
					else if (!cpuReq)
					begin
						cpuAck <= 1'b0;
						state <= Idle;
					end
				end
				default:
					state <= Idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/cacheGeometryPkg.sv
`default_nettype none

// ********************
// Address split and field widths
// ********************

package cacheGeometryPkg;

	localparam int TagBits = 21;
	localparam int IndexBits = 4;
	localparam int OffsetBits = 4;
	localparam int HaltBits = 4;
	localparam int Sets = 1 << IndexBits;
	localparam int LineBytes = 1 << OffsetBits;

	typedef logic [TagBits-1:0] tagT;
	typedef logic [HaltBits-1:0] haltT;
	typedef logic [IndexBits-1:0] indexT;
	typedef logic [OffsetBits-1:0] offsetT;
	typedef logic [7:0] byteT;

	// Byte 0 sits in the low bits
	typedef logic [LineBytes*8-1:0] lineT;

	// 29-bit byte address
	typedef struct packed {
		tagT tag;
		indexT index;
		offsetT offset;
	} addrT;

	// ********************
	// Per-set line state
	// ********************

	typedef struct packed {
		logic valid;
		logic dirty;
	} wayStateT;

endpackage

`default_nettype wire

// File: hw/cacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module cacheTop #(
	parameter int NumWays = 4
) (
	input wire clk,
	input wire reset,
	input wire cpuReq,
	input wire cacheBusPkg::cpuReqT cpuReqData,
	output logic cpuAck,
	output cacheGeometryPkg::byteT cpuReadByte,
	output logic memReq,
	output cacheBusPkg::memReqT memReqData,
	input wire memAck,
	input wire cacheBusPkg::memRespT memRespData
);

	cacheGeometryPkg::addrT lookupAddr;
	logic [NumWays-1:0] tagWrite;
	logic [NumWays-1:0] dataWrite;
	logic [NumWays-1:0] dirtyWrite;
	logic refill;
	logic dirtyIn;
	cacheGeometryPkg::lineT refillLine;
	cacheGeometryPkg::byteT writeByte;
	logic [NumWays-1:0] wayHits;
	logic [NumWays-1:0] wayDirty;
	cacheGeometryPkg::tagT [NumWays-1:0] wayTags;
	cacheGeometryPkg::lineT [NumWays-1:0] wayLines;
	logic hit;
	logic [$clog2(NumWays)-1:0] hitWay;
	cacheGeometryPkg::byteT hitByte;

	// ********************
	// Ways
	// ********************

	for (genvar w = 0; w < NumWays; w++)
	begin : gWay
		cacheWay way (
			.clk(clk), .reset(reset),
			.index(lookupAddr.index), .lookupTag(lookupAddr.tag),
			.tagWrite(tagWrite[w]), .dataWrite(dataWrite[w]),
			.writeOffset(lookupAddr.offset), .writeByte(writeByte),
			.refill(refill), .refillLine(refillLine),
			.dirtyWrite(dirtyWrite[w]), .dirtyIn(dirtyIn),
			.hit(wayHits[w]), .dirty(wayDirty[w]),
			.storedTag(wayTags[w]), .line(wayLines[w])
		);
	end

	waySelect #(.NumWays(NumWays)) selector (
		.wayHits(wayHits), .wayLines(wayLines), .offset(lookupAddr.offset),
		.hit(hit), .hitWay(hitWay), .hitByte(hitByte)
	);

	cacheController #(.NumWays(NumWays)) controller (
		.clk(clk), .reset(reset),
		.cpuReq(cpuReq), .cpuReqData(cpuReqData),
		.cpuAck(cpuAck), .cpuReadByte(cpuReadByte),
		.memReq(memReq), .memReqData(memReqData),
		.memAck(memAck), .memRespData(memRespData),
		.hit(hit), .hitWay(hitWay), .hitByte(hitByte),
		.wayDirty(wayDirty), .wayTags(wayTags), .wayLines(wayLines),
		.lookupAddr(lookupAddr),
		.tagWrite(tagWrite), .dataWrite(dataWrite),
		.refill(refill), .refillLine(refillLine), .writeByte(writeByte),
		.dirtyWrite(dirtyWrite), .dirtyIn(dirtyIn)
	);

endmodule

`default_nettype wire

// File: hw/cacheWay.sv
`timescale 1ns/1ps
`default_nettype none

module cacheWay (
	input wire clk,
	input wire reset,
	input wire cacheGeometryPkg::indexT index,
	input wire cacheGeometryPkg::tagT lookupTag,
	input wire tagWrite,
	input wire dataWrite,
	input wire cacheGeometryPkg::offsetT writeOffset,
	input wire cacheGeometryPkg::byteT writeByte,
	input wire refill,
	input wire cacheGeometryPkg::lineT refillLine,
	input wire dirtyWrite,
	input wire dirtyIn,
	output logic hit,
	output logic dirty,
	output cacheGeometryPkg::tagT storedTag,
	output cacheGeometryPkg::lineT line
);

	cacheGeometryPkg::haltT lookupHalt;
	cacheGeometryPkg::haltT storedHalt;
	cacheGeometryPkg::wayStateT curState;
	cacheGeometryPkg::wayStateT nextState;
	cacheGeometryPkg::lineT mergedLine;
	cacheGeometryPkg::lineT lineIn;
	logic haltMatch;
	logic tagMatch;

	// ********************
	// Storage
	// ********************

	assign lookupHalt = lookupTag[cacheGeometryPkg::HaltBits-1:0];

	setArray #(.entryT(cacheGeometryPkg::haltT)) haltArray (
		.clk(clk), .reset(reset),
		.write(tagWrite), .writeIndex(index), .writeEntry(lookupHalt),
		.readIndex(index), .readEntry(storedHalt)
	);

	setArray #(.entryT(cacheGeometryPkg::tagT)) tagArray (
		.clk(clk), .reset(reset),
		.write(tagWrite), .writeIndex(index), .writeEntry(lookupTag),
		.readIndex(index), .readEntry(storedTag)
	);

	setArray #(.entryT(cacheGeometryPkg::lineT)) dataArray (
		.clk(clk), .reset(reset),
		.write(dataWrite), .writeIndex(index), .writeEntry(lineIn),
		.readIndex(index), .readEntry(line)
	);

	// Valid only ever set here; a refill clears dirty through dirtyWrite
	assign nextState.valid = tagWrite ? 1'b1 : curState.valid;
	assign nextState.dirty = dirtyWrite ? dirtyIn : curState.dirty;

	setArray #(.entryT(cacheGeometryPkg::wayStateT)) stateArray (
		.clk(clk), .reset(reset),
		.write(tagWrite | dirtyWrite), .writeIndex(index), .writeEntry(nextState),
		.readIndex(index), .readEntry(curState)
	);

	// Byte merge into the current line
	always_comb
	begin
		mergedLine = line;
		mergedLine[8 * writeOffset +: 8] = writeByte;
	end

	assign lineIn = refill ? refillLine : mergedLine;

	// ********************
	// Way halting
	// ********************

	// Full compare only enabled by a halt tag match
	assign haltMatch = curState.valid && (storedHalt == lookupHalt);
	assign tagMatch = haltMatch && (storedTag == lookupTag);
	assign hit = tagMatch;
	assign dirty = curState.dirty;

endmodule

`default_nettype wire

// File: hw/setArray.sv
`timescale 1ns/1ps
`default_nettype none

// One entry per set, written on the edge, read combinationally
module setArray #(
	parameter type entryT = logic
) (
	input wire clk,
	input wire reset,
	input wire write,
	input wire cacheGeometryPkg::indexT writeIndex,
	input wire entryT writeEntry,
	input wire cacheGeometryPkg::indexT readIndex,
	output entryT readEntry
);

	entryT entries [cacheGeometryPkg::Sets];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < cacheGeometryPkg::Sets; s++)
				entries[s] <= '0;
		end
		else if (write)
		begin
			entries[writeIndex] <= writeEntry;
		end
	end

	assign readEntry = entries[readIndex];

endmodule

`default_nettype wire

// File: hw/waySelect.sv
`timescale 1ns/1ps
`default_nettype none

module waySelect #(
	parameter int NumWays = 4
) (
	input wire [NumWays-1:0] wayHits,
	input wire cacheGeometryPkg::lineT [NumWays-1:0] wayLines,
	input wire cacheGeometryPkg::offsetT offset,
	output logic hit,
	output logic [$clog2(NumWays)-1:0] hitWay,
	output cacheGeometryPkg::byteT hitByte
);

	localparam int WayBits = $clog2(NumWays);

	cacheGeometryPkg::lineT hitLine;

	// ********************
	// One-hot to way number
	// ********************

	// At most one way hits for a given index
	always_comb
	begin
		hitWay = '0;
		for (int w = 0; w < NumWays; w++)
		begin
			if (wayHits[w])
				hitWay = WayBits'(w);
		end
	end

	assign hit = |wayHits;

	// ********************
	// Line and byte select
	// ********************

	assign hitLine = wayLines[hitWay];
	assign hitByte = hitLine[8 * offset +: 8];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cacheTb -f sim.f -o cacheSim

out=$(./obj_dir/cacheSim 2>&1) || { printf '%s\n' "$out"; exit 1; }
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1

// File: sim.f
hw/cacheGeometryPkg.sv
hw/cacheBusPkg.sv
hw/setArray.sv
hw/cacheWay.sv
hw/waySelect.sv
hw/cacheController.sv
hw/cacheTop.sv
testbench/cacheTop_props.sv
testbench/cacheTb.sv

// File: testbench/cacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module cacheTb;

	localparam int NumWays = 4;
	localparam int AckLimit = 400;
	localparam int RandomTests = 40;

	typedef struct {
		string name;
		cacheBusPkg::cpuOpT op;
		cacheGeometryPkg::addrT addr;
		cacheGeometryPkg::byteT wdata;
		cacheGeometryPkg::byteT expRead;
		bit expWb;
		bit expMiss;
		cacheBusPkg::memReqT wbReq;
		cacheBusPkg::memReqT fillReq;
	} testT;

	logic clk = 1'b0;
	logic reset;
	logic cpuReq;
	cacheBusPkg::cpuReqT cpuReqData;
	logic cpuAck;
	cacheGeometryPkg::byteT cpuReadByte;
	logic memReq;
	cacheBusPkg::memReqT memReqData;
	logic memAck = 1'b0;
	cacheBusPkg::memRespT memRespData = '0;

	testT tests[$];
	cacheBusPkg::memReqT memLog[$];
	cacheGeometryPkg::lineT memLines [bit [24:0]];
	cacheGeometryPkg::byteT refMem [bit [28:0]];
	// Tag and pointer model of each set
	cacheGeometryPkg::tagT mTag [cacheGeometryPkg::Sets][NumWays];
	bit mValid [cacheGeometryPkg::Sets][NumWays];
	bit mDirty [cacheGeometryPkg::Sets][NumWays];
	int mPtr [cacheGeometryPkg::Sets];
	cacheGeometryPkg::tagT tagPool [6];
	cacheGeometryPkg::indexT setPool [3];
	int ackDelay = 0;
	int errors = 0;
	int testsRun = 0;
	bit aborted = 1'b0;

	cacheTop #(.NumWays(NumWays)) UUT (
		.clk(clk), .reset(reset),
		.cpuReq(cpuReq), .cpuReqData(cpuReqData),
		.cpuAck(cpuAck), .cpuReadByte(cpuReadByte),
		.memReq(memReq), .memReqData(memReqData),
		.memAck(memAck), .memRespData(memRespData)
	);

	always #10 clk = ~clk;

	// Initial byte folds the whole address
	function automatic cacheGeometryPkg::byteT initByte(input logic [28:0] addr);
		return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ {3'b000, addr[28:24]};
	endfunction

	function automatic cacheGeometryPkg::byteT refByte(input cacheGeometryPkg::addrT addr);
		if (refMem.exists(addr))
			return refMem[addr];
		return initByte(addr);
	endfunction

	function automatic cacheGeometryPkg::lineT readLine(input logic [24:0] lineAddr);
		cacheGeometryPkg::lineT line;
		if (memLines.exists(lineAddr))
			return memLines[lineAddr];
		for (int b = 0; b < cacheGeometryPkg::LineBytes; b++)
			line[8*b +: 8] = initByte({lineAddr, cacheGeometryPkg::offsetT'(b)});
		return line;
	endfunction

	function automatic cacheGeometryPkg::addrT mkAddr(input cacheGeometryPkg::tagT tag,
		input int index, input int offset);
		cacheGeometryPkg::addrT a;
		a.tag = tag;
		a.index = cacheGeometryPkg::indexT'(index);
		a.offset = cacheGeometryPkg::offsetT'(offset);
		return a;
	endfunction

	// ********************
	// Memory model
	// ********************

	always @(negedge clk)
	begin
		if (memReq && !memAck)
		begin
			if (ackDelay > 0)
				ackDelay <= ackDelay - 1;
			else
			begin
				memLog.push_back(memReqData);
				if (memReqData.op == cacheBusPkg::MemLineWrite)
					memLines[memReqData.lineAddr] = memReqData.line;
				else
					memRespData.line <= readLine(memReqData.lineAddr);
				memAck <= 1'b1;
				ackDelay <= int'($urandom_range(0, 3));
			end
		end
		else if (!memReq && memAck)
			memAck <= 1'b0;
	end

	// ********************
	// Stimulus table with predicted results
	// ********************

	task automatic addTest(input string name, input cacheBusPkg::cpuOpT op,
		input cacheGeometryPkg::addrT addr, input cacheGeometryPkg::byteT wdata);
		testT t;
		int way;
		way = -1;
		t.name = name;
		t.op = op;
		t.addr = addr;
		t.wdata = wdata;
		t.expRead = '0;
		t.expWb = 1'b0;
		t.expMiss = 1'b0;
		t.wbReq = '0;
		t.fillReq = '0;
		for (int w = 0; w < NumWays; w++)
		begin
			if (mValid[addr.index][w] && mTag[addr.index][w] == addr.tag)
				way = w;
		end
		if (way < 0)
		begin
			// Miss takes the round-robin victim
			way = mPtr[addr.index];
			t.expMiss = 1'b1;
			t.fillReq.op = cacheBusPkg::MemLineRead;
			t.fillReq.lineAddr.tag = addr.tag;
			t.fillReq.lineAddr.index = addr.index;
			if (mValid[addr.index][way] && mDirty[addr.index][way])
			begin
				t.expWb = 1'b1;
				t.wbReq.op = cacheBusPkg::MemLineWrite;
				t.wbReq.lineAddr.tag = mTag[addr.index][way];
				t.wbReq.lineAddr.index = addr.index;
				for (int b = 0; b < cacheGeometryPkg::LineBytes; b++)
					t.wbReq.line[8*b +: 8] = refByte(mkAddr(mTag[addr.index][way], int'(addr.index), b));
			end
			mTag[addr.index][way] = addr.tag;
			mValid[addr.index][way] = 1'b1;
			mDirty[addr.index][way] = 1'b0;
			mPtr[addr.index] = (way + 1) % NumWays;
		end
		if (op == cacheBusPkg::CpuWrite)
		begin
			mDirty[addr.index][way] = 1'b1;
			refMem[addr] = wdata;
		end
		else
			t.expRead = refByte(addr);
		tests.push_back(t);
	endtask

	// ********************
	// Checks
	// ********************

	task automatic checkByte(input string name, input cacheGeometryPkg::byteT expected,
		input cacheGeometryPkg::byteT actual);
		if (expected !== actual)
		begin
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkReq(input string name, input cacheBusPkg::memReqT expected,
		input cacheBusPkg::memReqT actual);
		if (expected !== actual)
		begin
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (expected !== actual)
		begin
			$display("ERR %s: expected %b, actual %b", name, expected, actual);
			errors++;
		end
	endtask

	task automatic waitAck(input logic level, input string name, output bit ok);
		int cycles;
		cycles = 0;
		while (cpuAck !== level && cycles < AckLimit)
		begin
			@(negedge clk);
			cycles++;
		end
		ok = (cpuAck === level);
		if (!ok)
		begin
			$display("%s: cpuAck did not go to %0b within %0d cycles", name, level, AckLimit);
			errors++;
			aborted = 1'b1;
		end
	endtask

	task automatic runTest(input testT t);
		int errsBefore;
		int logStart;
		int expCount;
		int k;
		bit ok;
		errsBefore = errors;
		logStart = memLog.size();
		cpuReqData.op = t.op;
		cpuReqData.addr = t.addr;
		cpuReqData.writeByte = t.wdata;
		cpuReq = 1'b1;
		waitAck(1'b1, t.name, ok);
		if (ok)
		begin
			if (t.op == cacheBusPkg::CpuRead)
				checkByte(t.name, t.expRead, cpuReadByte);
			cpuReq = 1'b0;
			waitAck(1'b0, t.name, ok);
		end
		if (ok)
		begin
			expCount = int'(t.expWb) + int'(t.expMiss);
			k = logStart;
			if (memLog.size() - logStart != expCount)
			begin
				$display("%s: expected %0d memory requests but saw %0d", t.name, expCount,
					memLog.size() - logStart);
				errors++;
			end
			else
			begin
				if (t.expWb)
				begin
					checkReq(t.name, t.wbReq, memLog[k]);
					k++;
				end
				if (t.expMiss)
					checkReq(t.name, t.fillReq, memLog[k]);
			end
		end
		testsRun++;
		$display("%s: %s", t.name, (errors == errsBefore) ? "ok" : "mismatch");
	endtask

	// ********************
	// Main sequence
	// ********************

	initial
	begin
		cacheGeometryPkg::addrT a;
		bit isWrite;
		void'($urandom(88981));
		reset = 1'b1;
		cpuReq = 1'b0;
		cpuReqData = '0;
		tagPool = '{21'h00005, 21'h00015, 21'h10005, 21'h0000A, 21'h1F00A, 21'h00003};
		setPool = '{4'd3, 4'd7, 4'd12};

		// Hit and write hit in set 5, then five more tags for round-robin eviction
		addTest("coldRead", cacheBusPkg::CpuRead, mkAddr(21'h00012, 5, 3), 8'h00);
		addTest("sameLineRead", cacheBusPkg::CpuRead, mkAddr(21'h00012, 5, 9), 8'h00);
		addTest("writeHit", cacheBusPkg::CpuWrite, mkAddr(21'h00012, 5, 4), 8'hA5);
		addTest("readBack", cacheBusPkg::CpuRead, mkAddr(21'h00012, 5, 4), 8'h00);
		addTest("fillWay1", cacheBusPkg::CpuRead, mkAddr(21'h00022, 5, 0), 8'h00);
		addTest("fillWay2", cacheBusPkg::CpuRead, mkAddr(21'h00103, 5, 1), 8'h00);
		addTest("fillWay3", cacheBusPkg::CpuRead, mkAddr(21'h01002, 5, 2), 8'h00);
		addTest("evictDirty", cacheBusPkg::CpuRead, mkAddr(21'h10012, 5, 4), 8'h00);
		addTest("evictClean", cacheBusPkg::CpuRead, mkAddr(21'h00007, 5, 6), 8'h00);
		addTest("reloadWritten", cacheBusPkg::CpuRead, mkAddr(21'h00012, 5, 4), 8'h00);
		addTest("writeMiss", cacheBusPkg::CpuWrite, mkAddr(21'h0ABCD, 9, 2), 8'h3C);
		addTest("neighborRead", cacheBusPkg::CpuRead, mkAddr(21'h0ABCD, 9, 3), 8'h00);
		addTest("mergedRead", cacheBusPkg::CpuRead, mkAddr(21'h0ABCD, 9, 2), 8'h00);
		for (int n = 0; n < RandomTests; n++)
		begin
			a = mkAddr(tagPool[$urandom_range(0, 5)], int'(setPool[$urandom_range(0, 2)]),
				int'($urandom_range(0, 15)));
			isWrite = ($urandom_range(0, 1) == 1);
			addTest($sformatf("random%0d", n),
				isWrite ? cacheBusPkg::CpuWrite : cacheBusPkg::CpuRead, a,
				cacheGeometryPkg::byteT'($urandom));
		end

		repeat (8) @(negedge clk);
		reset = 1'b0;
		checkFlag("resetCpuAck", 1'b0, cpuAck);
		checkFlag("resetMemReq", 1'b0, memReq);
		testsRun++;
		$display("resetState: %s", (errors == 0) ? "ok" : "mismatch");

		for (int i = 0; i < tests.size(); i++)
		begin
			if (!aborted)
				runTest(tests[i]);
		end

		$display("%0d tests run, %0d errors", testsRun, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/cacheTop_props.sv
`timescale 1ns/1ps
`default_nettype none

module cacheTopProps (
	input wire clk,
	input wire reset,
	input wire cpuReq,
	input wire cpuAck,
	input wire memReq,
	input wire memAck,
	input wire cacheBusPkg::memReqT memReqData
);

	// ********************
	// CPU handshake
	// ********************

	ackRise: assert property (@(posedge clk) disable iff (reset) $rose(cpuAck) |-> $past(cpuReq))
		else $error("cpuAck rose while cpuReq was low");

	ackFall: assert property (@(posedge clk) disable iff (reset) $fell(cpuAck) |-> !$past(cpuReq))
		else $error("cpuAck fell before cpuReq was low");

	// ********************
	// Memory handshake
	// ********************

	reqStable: assert property (@(posedge clk) disable iff (reset)
		memReq && $past(memReq) |-> $stable(memReqData))
		else $error("memReqData changed while memReq was high");

	reqRise: assert property (@(posedge clk) disable iff (reset) $rose(memReq) |-> !$past(memAck))
		else $error("memReq rose while memAck was high");

endmodule

bind cacheTop cacheTopProps props (
	.clk(clk),
	.reset(reset),
	.cpuReq(cpuReq),
	.cpuAck(cpuAck),
	.memReq(memReq),
	.memAck(memAck),
	.memReqData(memReqData)
);

`default_nettype wire
